/* rtl/anabellek_consts.svh */
`ifndef ANABELLEK_CONSTS_SVH
`define ANABELLEK_CONSTS_SVH

// iomem bus word width
`define ANABELLEK_KELIME_W 32

// One cache block of 16 bytes
`define ANABELLEK_OBEK_W 128

`define ANABELLEK_VURUS_SAYISI 4    // Beats per block

// Entries in each request queue
`define ANABELLEK_KUYRUK_DERINLIK 2

`endif

/* rtl/anabellek_pkg.sv */
`include "anabellek_consts.svh"

package anabellek_pkg;

    // Which cache side the request comes from
    typedef enum logic {
        KAYNAK_GETIR  = 1'b0,
        KAYNAK_BELLEK = 1'b1
    } kaynak_e;

    // Instruction side reads only
    typedef struct packed {
        logic [`ANABELLEK_KELIME_W-1:0] adres;  // Block base address
    } getir_istek_t;

    typedef struct packed {
        logic [`ANABELLEK_KELIME_W-1:0] adres;
        logic                           yaz;    // 1 write, 0 read
        logic [`ANABELLEK_OBEK_W-1:0]   obek;   // Block to write
    } bellek_istek_t;

    // Request after arbitration, tagged with its side
    typedef struct packed {
        kaynak_e                        kaynak;
        logic [`ANABELLEK_KELIME_W-1:0] adres;
        logic                           yaz;
        logic [`ANABELLEK_OBEK_W-1:0]   obek;
    } obek_istek_t;

    typedef struct packed {
        kaynak_e                      kaynak;
        logic                         yaz;
        logic [`ANABELLEK_OBEK_W-1:0] obek;   // Read block
    } obek_yanit_t;

endpackage

/* rtl/istek_kuyrugu.sv */
`timescale 1ns/1ps
`include "anabellek_consts.svh"

module istek_kuyrugu #(
    parameter type yuk_t = logic
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic giris_valid_i,
    output logic giris_ready_o,
    input  yuk_t giris_i,
    output logic cikis_valid_o,
    input  logic cikis_ready_i,
    output yuk_t cikis_o
);
    localparam int DERINLIK = `ANABELLEK_KUYRUK_DERINLIK;
    localparam int PTR_W    = (DERINLIK > 1) ? $clog2(DERINLIK) : 1;
    localparam int SAYAC_W  = $clog2(DERINLIK + 1);

    yuk_t               kayit_q [DERINLIK];
    logic [PTR_W-1:0]   yaz_ptr_q;
    logic [PTR_W-1:0]   oku_ptr_q;
    logic [SAYAC_W-1:0] sayac_q;   // Number of full entries
    logic               yaz;
    logic               oku;

    assign giris_ready_o = (sayac_q != SAYAC_W'(DERINLIK));  // Low only when full
    assign cikis_valid_o = (sayac_q != '0);
    assign cikis_o       = kayit_q[oku_ptr_q];
    assign yaz           = giris_valid_i && giris_ready_o;
    assign oku           = cikis_valid_o && cikis_ready_i;

    always_ff @(posedge clk_i) begin
        if (yaz) begin
            kayit_q[yaz_ptr_q] <= giris_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            yaz_ptr_q <= '0;
            oku_ptr_q <= '0;
            sayac_q   <= '0;
        end else begin
            if (yaz) begin
                yaz_ptr_q <= (yaz_ptr_q == PTR_W'(DERINLIK - 1)) ? '0 : yaz_ptr_q + 1'b1;
            end
            if (oku) begin
                oku_ptr_q <= (oku_ptr_q == PTR_W'(DERINLIK - 1)) ? '0 : oku_ptr_q + 1'b1;
            end
            case ({yaz, oku})
                2'b10:   sayac_q <= sayac_q + 1'b1;
                2'b01:   sayac_q <= sayac_q - 1'b1;
                default: sayac_q <= sayac_q;   // Both or neither
            endcase
        end
    end

    // While full and not drained, no write reaches the head entry
    a_dolu_yazma_yok : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (sayac_q == SAYAC_W'(DERINLIK)) && !oku
        |=> (sayac_q == SAYAC_W'(DERINLIK)) && $stable(cikis_o));

endmodule

/* rtl/istek_hakemi.sv */
`timescale 1ns/1ps
`include "anabellek_consts.svh"

module istek_hakemi import anabellek_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          getir_valid_i,
    output logic          getir_ready_o,
    input  getir_istek_t  getir_i,
    input  logic          bellek_valid_i,
    output logic          bellek_ready_o,
    input  bellek_istek_t bellek_i,
    output logic          istek_valid_o,
    input  logic          istek_ready_i,
    output obek_istek_t   istek_o
);
    localparam int ADRES_W  = `ANABELLEK_KELIME_W;
    localparam int HIZALA_W = $clog2(`ANABELLEK_OBEK_W / 8);  // Byte offset within block

    kaynak_e son_q;     // Side served last
    kaynak_e secim;
    logic    aktarim;

    // With both sides waiting, the one not served last goes
    always_comb begin
        if (getir_valid_i && bellek_valid_i) begin
            secim = (son_q == KAYNAK_GETIR) ? KAYNAK_BELLEK : KAYNAK_GETIR;
        end else if (bellek_valid_i) begin
            secim = KAYNAK_BELLEK;
        end else begin
            secim = KAYNAK_GETIR;
        end
    end

    assign istek_valid_o  = getir_valid_i || bellek_valid_i;
    assign getir_ready_o  = istek_ready_i && (secim == KAYNAK_GETIR);
    assign bellek_ready_o = istek_ready_i && (secim == KAYNAK_BELLEK);
    assign aktarim        = istek_valid_o && istek_ready_i;

    always_comb begin
        istek_o.kaynak = secim;
        if (secim == KAYNAK_BELLEK) begin
            istek_o.adres = {bellek_i.adres[ADRES_W-1:HIZALA_W], {HIZALA_W{1'b0}}};
            istek_o.yaz   = bellek_i.yaz;
            istek_o.obek  = bellek_i.obek;
        end else begin
            istek_o.adres = {getir_i.adres[ADRES_W-1:HIZALA_W], {HIZALA_W{1'b0}}};
            istek_o.yaz   = 1'b0;   // Instruction side only reads
            istek_o.obek  = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            son_q <= KAYNAK_BELLEK;   // Fetch side wins the first tie
        end else if (aktarim) begin
            son_q <= secim;
        end
    end

    a_tek_izin : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(getir_valid_i && getir_ready_o && bellek_valid_i && bellek_ready_o));

endmodule

/* rtl/obek_aktarici.sv */
`timescale 1ns/1ps
`include "anabellek_consts.svh"

module obek_aktarici import anabellek_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             istek_valid_i,
    output logic                             istek_ready_o,
    input  obek_istek_t                      istek_i,
    output logic                             yanit_valid_o,
    input  logic                             yanit_ready_i,
    output obek_yanit_t                      yanit_o,
    output logic                             iomem_valid_o,
    input  logic                             iomem_ready_i,
    output logic [`ANABELLEK_KELIME_W-1:0]   iomem_addr_o,
    output logic [`ANABELLEK_KELIME_W-1:0]   iomem_wdata_o,
    output logic [`ANABELLEK_KELIME_W/8-1:0] iomem_wstrb_o,
    input  logic [`ANABELLEK_KELIME_W-1:0]   iomem_rdata_i
);
    localparam int KELIME_W = `ANABELLEK_KELIME_W;
    localparam int OBEK_W   = `ANABELLEK_OBEK_W;
    localparam int VURUS_N  = `ANABELLEK_VURUS_SAYISI;
    localparam int VURUS_W  = $clog2(VURUS_N);
    localparam int BAYT_W   = $clog2(KELIME_W / 8);

    typedef enum logic [1:0] {
        BOSTA,
        VURUS,
        YANIT
    } durum_e;

    durum_e             durum_q;
    logic [VURUS_W-1:0] vurus_q;    // Current beat index
    obek_istek_t        istek_q;
    logic [OBEK_W-1:0]  okunan_q;   // Block being rebuilt on a read
    logic               vurus_bitti;
    logic               son_vurus;

    assign istek_ready_o = (durum_q == BOSTA);
    assign yanit_valid_o = (durum_q == YANIT);
    assign iomem_valid_o = (durum_q == VURUS);

    // Beat k goes to base + 4k
    assign iomem_addr_o  = istek_q.adres + KELIME_W'({vurus_q, {BAYT_W{1'b0}}});
    assign iomem_wdata_o = istek_q.obek[vurus_q*KELIME_W +: KELIME_W];
    assign iomem_wstrb_o = {(KELIME_W/8){istek_q.yaz && iomem_valid_o}};

    assign vurus_bitti = iomem_valid_o && iomem_ready_i;
    assign son_vurus   = (vurus_q == VURUS_W'(VURUS_N - 1));

    assign yanit_o.kaynak = istek_q.kaynak;
    assign yanit_o.yaz    = istek_q.yaz;
    assign yanit_o.obek   = okunan_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            durum_q <= BOSTA;
            vurus_q <= '0;
        end else begin
            case (durum_q)
                BOSTA: begin
                    if (istek_valid_i) begin
                        durum_q <= VURUS;
                        vurus_q <= '0;
                    end
                end
                VURUS: begin
                    if (vurus_bitti) begin
                        vurus_q <= vurus_q + 1'b1;
                        if (son_vurus) begin
                            durum_q <= YANIT;   // Response valid on the next cycle
                        end
                    end
                end
                YANIT: begin
                    if (yanit_ready_i) begin
                        durum_q <= BOSTA;
                    end
                end
                default: durum_q <= BOSTA;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (istek_valid_i && istek_ready_o) begin
            istek_q <= istek_i;
        end
        if (vurus_bitti && !istek_q.yaz) begin
            okunan_q[vurus_q*KELIME_W +: KELIME_W] <= iomem_rdata_i;
        end
    end

    // A beat on hold keeps its address and data
    a_vurus_kararli : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        iomem_valid_o && !iomem_ready_i
        |=> iomem_valid_o && $stable(iomem_addr_o) && $stable(iomem_wdata_o));

endmodule

/* rtl/yanit_dagitici.sv */
`timescale 1ns/1ps
`include "anabellek_consts.svh"

module yanit_dagitici import anabellek_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         yanit_valid_i,
    output logic                         yanit_ready_o,
    input  obek_yanit_t                  yanit_i,
    output logic                         getir_yanit_valid_o,
    input  logic                         getir_yanit_ready_i,
    output logic [`ANABELLEK_OBEK_W-1:0] getir_yanit_o,
    output logic                         bellek_yanit_valid_o,
    input  logic                         bellek_yanit_ready_i,
    output logic [`ANABELLEK_OBEK_W-1:0] bellek_yanit_o
);
    logic        dolu_q;    // Register holds a response
    obek_yanit_t yanit_q;
    logic        teslim;

    assign yanit_ready_o = !dolu_q;

    assign getir_yanit_valid_o  = dolu_q && (yanit_q.kaynak == KAYNAK_GETIR);
    assign bellek_yanit_valid_o = dolu_q && (yanit_q.kaynak == KAYNAK_BELLEK);
    assign getir_yanit_o        = yanit_q.obek;
    assign bellek_yanit_o       = yanit_q.yaz ? '0 : yanit_q.obek;  // No data after a write

    assign teslim = (getir_yanit_valid_o && getir_yanit_ready_i)
                 || (bellek_yanit_valid_o && bellek_yanit_ready_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dolu_q <= 1'b0;
        end else if (yanit_valid_i && yanit_ready_o) begin
            dolu_q <= 1'b1;
        end else if (teslim) begin
            dolu_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (yanit_valid_i && yanit_ready_o) begin
            yanit_q <= yanit_i;
        end
    end

    a_tek_taraf : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(getir_yanit_valid_o && bellek_yanit_valid_o));

endmodule

/* rtl/anabellek_denetleyici.sv */
`timescale 1ns/1ps
`include "anabellek_consts.svh"

module anabellek_denetleyici import anabellek_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             getir_istek_valid_i,
    output logic                             getir_istek_ready_o,
    input  getir_istek_t                     getir_istek_i,
    input  logic                             bellek_istek_valid_i,
    output logic                             bellek_istek_ready_o,
    input  bellek_istek_t                    bellek_istek_i,
    output logic                             getir_yanit_valid_o,
    input  logic                             getir_yanit_ready_i,
    output logic [`ANABELLEK_OBEK_W-1:0]     getir_yanit_o,
    output logic                             bellek_yanit_valid_o,
    input  logic                             bellek_yanit_ready_i,
    output logic [`ANABELLEK_OBEK_W-1:0]     bellek_yanit_o,
    output logic                             iomem_valid_o,
    input  logic                             iomem_ready_i,
    output logic [`ANABELLEK_KELIME_W-1:0]   iomem_addr_o,
    output logic [`ANABELLEK_KELIME_W-1:0]   iomem_wdata_o,
    output logic [`ANABELLEK_KELIME_W/8-1:0] iomem_wstrb_o,
    input  logic [`ANABELLEK_KELIME_W-1:0]   iomem_rdata_i
);
    // Queues to arbiter
    logic          getir_valid;
    logic          getir_ready;
    getir_istek_t  getir_istek;
    logic          bellek_valid;
    logic          bellek_ready;
    bellek_istek_t bellek_istek;

    // Arbiter to sequencer
    logic        istek_valid;
    logic        istek_ready;
    obek_istek_t istek;

    // Sequencer to router
    logic        yanit_valid;
    logic        yanit_ready;
    obek_yanit_t yanit;

    istek_kuyrugu #(.yuk_t(getir_istek_t)) getir_kuyruk (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .giris_valid_i(getir_istek_valid_i), .giris_ready_o(getir_istek_ready_o),
        .giris_i(getir_istek_i),
        .cikis_valid_o(getir_valid), .cikis_ready_i(getir_ready), .cikis_o(getir_istek)
    );

    istek_kuyrugu #(.yuk_t(bellek_istek_t)) bellek_kuyruk (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .giris_valid_i(bellek_istek_valid_i), .giris_ready_o(bellek_istek_ready_o),
        .giris_i(bellek_istek_i),
        .cikis_valid_o(bellek_valid), .cikis_ready_i(bellek_ready), .cikis_o(bellek_istek)
    );

    istek_hakemi hakem (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .getir_valid_i(getir_valid), .getir_ready_o(getir_ready), .getir_i(getir_istek),
        .bellek_valid_i(bellek_valid), .bellek_ready_o(bellek_ready), .bellek_i(bellek_istek),
        .istek_valid_o(istek_valid), .istek_ready_i(istek_ready), .istek_o(istek)
    );

    obek_aktarici aktarici (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .istek_valid_i(istek_valid), .istek_ready_o(istek_ready), .istek_i(istek),
        .yanit_valid_o(yanit_valid), .yanit_ready_i(yanit_ready), .yanit_o(yanit),
        .iomem_valid_o(iomem_valid_o), .iomem_ready_i(iomem_ready_i),
        .iomem_addr_o(iomem_addr_o), .iomem_wdata_o(iomem_wdata_o),
        .iomem_wstrb_o(iomem_wstrb_o), .iomem_rdata_i(iomem_rdata_i)
    );

    yanit_dagitici dagitici (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .yanit_valid_i(yanit_valid), .yanit_ready_o(yanit_ready), .yanit_i(yanit),
        .getir_yanit_valid_o(getir_yanit_valid_o), .getir_yanit_ready_i(getir_yanit_ready_i),
        .getir_yanit_o(getir_yanit_o),
        .bellek_yanit_valid_o(bellek_yanit_valid_o), .bellek_yanit_ready_i(bellek_yanit_ready_i),
        .bellek_yanit_o(bellek_yanit_o)
    );

endmodule

/* tests/iomem_model.sv */
`timescale 1ns/1ps
`include "anabellek_consts.svh"

module iomem_model #(
    parameter logic [31:0] TOHUM = 32'h1
) (
    input  logic                             clk_i,
    input  logic                             iomem_valid_i,
    input  logic [`ANABELLEK_KELIME_W-1:0]   iomem_addr_i,
    input  logic [`ANABELLEK_KELIME_W-1:0]   iomem_wdata_i,
    input  logic [`ANABELLEK_KELIME_W/8-1:0] iomem_wstrb_i,
    output logic                             iomem_ready_o,
    output logic [`ANABELLEK_KELIME_W-1:0]   iomem_rdata_o
);
    logic [`ANABELLEK_KELIME_W-1:0] mem [256];  // Word i at byte address 4i
    int                             bekle;
    logic                           sayiyor;    // Delay already picked for this beat
    int                             i;
    logic [31:0]                    tohum_v;

    initial begin
        iomem_ready_o = 1'b0;
        iomem_rdata_o = '0;
        sayiyor = 1'b0;
        bekle = 0;
        for (i = 0; i < 256; i++) begin
            mem[i] = 32'ha5a5_0000 ^ (i << 2);
        end
        tohum_v = TOHUM;
        void'($urandom(tohum_v));
        forever begin
            @(posedge clk_i);
            #2;
            if (iomem_ready_o) begin
                iomem_ready_o = 1'b0;   // Beat ended on this edge
            end else if (iomem_valid_i) begin
                if (!sayiyor) begin
                    bekle = $urandom % 4;
                    sayiyor = 1'b1;
                end
                if (bekle == 0) begin
                    sayiyor = 1'b0;
                    iomem_ready_o = 1'b1;
                    if (iomem_wstrb_i == 4'hf) begin
                        mem[iomem_addr_i[9:2]] = iomem_wdata_i;
                    end else begin
                        iomem_rdata_o = mem[iomem_addr_i[9:2]];
                    end
                end else begin
                    bekle = bekle - 1;
                end
            end
        end
    end

endmodule

/* tests/tb_anabellek_denetleyici.sv */
`timescale 1ns/1ps
`include "anabellek_consts.svh"

module tb_anabellek_denetleyici import anabellek_pkg::*; ();
    localparam int SATIR_N = 12;
    localparam int SINIR   = SATIR_N * 40 + 100;   // Cycle limit of the run

    typedef struct packed {
        kaynak_e                        taraf;
        logic                           yaz;
        logic [`ANABELLEK_KELIME_W-1:0] adres;
        logic [`ANABELLEK_OBEK_W-1:0]   obek;
        logic                           birlikte;  // Launch with the next row
        logic [7:0]                     bekle;     // Cycles of response ready held low
    } satir_t;

    logic                             clk;
    logic                             rst_n;
    logic                             getir_istek_valid;
    logic                             getir_istek_ready;
    getir_istek_t                     getir_istek;
    logic                             bellek_istek_valid;
    logic                             bellek_istek_ready;
    bellek_istek_t                    bellek_istek;
    logic                             getir_yanit_valid;
    logic                             getir_yanit_ready;
    logic [`ANABELLEK_OBEK_W-1:0]     getir_yanit;
    logic                             bellek_yanit_valid;
    logic                             bellek_yanit_ready;
    logic [`ANABELLEK_OBEK_W-1:0]     bellek_yanit;
    logic                             iomem_valid;
    logic                             iomem_ready;
    logic [`ANABELLEK_KELIME_W-1:0]   iomem_addr;
    logic [`ANABELLEK_KELIME_W-1:0]   iomem_wdata;
    logic [`ANABELLEK_KELIME_W/8-1:0] iomem_wstrb;
    logic [`ANABELLEK_KELIME_W-1:0]   iomem_rdata;

    satir_t                       tablo [SATIR_N];
    logic [`ANABELLEK_OBEK_W-1:0] ref_mem [64];    // Expected contents by block
    obek_istek_t                  obek_sirasi [$]; // Blocks in expected grant order
    obek_yanit_t                  yanit_sirasi [$];
    obek_istek_t                  simdiki;
    kaynak_e                      son_taraf;
    int                           hata_n;
    int                           dongu_n;
    int                           vurus_n;
    int                           bekleyen_n;
    int                           getir_bekle;
    int                           bellek_bekle;
    logic                         getir_tut;       // Response was held on the last sample
    logic                         bellek_tut;

    anabellek_denetleyici dut0 (
        .clk_i(clk), .rst_n_i(rst_n),
        .getir_istek_valid_i(getir_istek_valid), .getir_istek_ready_o(getir_istek_ready),
        .getir_istek_i(getir_istek),
        .bellek_istek_valid_i(bellek_istek_valid), .bellek_istek_ready_o(bellek_istek_ready),
        .bellek_istek_i(bellek_istek),
        .getir_yanit_valid_o(getir_yanit_valid), .getir_yanit_ready_i(getir_yanit_ready),
        .getir_yanit_o(getir_yanit),
        .bellek_yanit_valid_o(bellek_yanit_valid), .bellek_yanit_ready_i(bellek_yanit_ready),
        .bellek_yanit_o(bellek_yanit),
        .iomem_valid_o(iomem_valid), .iomem_ready_i(iomem_ready),
        .iomem_addr_o(iomem_addr), .iomem_wdata_o(iomem_wdata),
        .iomem_wstrb_o(iomem_wstrb), .iomem_rdata_i(iomem_rdata)
    );

    iomem_model #(.TOHUM(32'hc477_e4e1)) iomem0 (
        .clk_i(clk), .iomem_valid_i(iomem_valid), .iomem_addr_i(iomem_addr),
        .iomem_wdata_i(iomem_wdata), .iomem_wstrb_i(iomem_wstrb),
        .iomem_ready_o(iomem_ready), .iomem_rdata_o(iomem_rdata)
    );

    task automatic report_error(input string metin);
        hata_n++;
        $display("ERROR at %0t: %s", $time, metin);
    endtask

    task automatic check_bit(input string ad, input logic gercek, input logic beklenen);
        if (gercek !== beklenen) begin
            hata_n++;
            $display("FAIL %0t %s got %b expected %b", $time, ad, gercek, beklenen);
        end
    endtask

    task automatic check_kelime(input string ad, input logic [`ANABELLEK_KELIME_W-1:0] gercek,
                                input logic [`ANABELLEK_KELIME_W-1:0] beklenen);
        if (gercek !== beklenen) begin
            hata_n++;
            $display("FAIL %0t %s got %h expected %h", $time, ad, gercek, beklenen);
        end
    endtask

    task automatic check_blok(input string ad, input logic [`ANABELLEK_OBEK_W-1:0] gercek,
                              input logic [`ANABELLEK_OBEK_W-1:0] beklenen);
        if (gercek !== beklenen) begin
            hata_n++;
            $display("FAIL %0t %s got %h expected %h", $time, ad, gercek, beklenen);
        end
    endtask

    task automatic check_kaynak(input string ad, input kaynak_e gercek, input kaynak_e beklenen);
        if (gercek !== beklenen) begin
            hata_n++;
            $display("FAIL %0t %s got %s expected %s", $time, ad, gercek.name(), beklenen.name());
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] adres);
        return 32'ha5a5_0000 ^ adres;   // Same pattern as the iomem model
    endfunction

    task automatic add_row(input int i, input kaynak_e taraf, input logic yaz,
                           input logic [31:0] adres, input logic [127:0] obek,
                           input logic birlikte, input int bekle);
        tablo[i].taraf    = taraf;
        tablo[i].yaz      = yaz;
        tablo[i].adres    = adres;
        tablo[i].obek     = obek;
        tablo[i].birlikte = birlikte;
        tablo[i].bekle    = 8'(bekle);
    endtask

    // Records the expected block and response, then drives the request
    task automatic launch_row(input int i);
        satir_t      s;
        obek_istek_t e;
        obek_yanit_t y;
        s = tablo[i];
        e.kaynak = s.taraf;
        e.adres  = {s.adres[31:4], 4'h0};
        e.yaz    = (s.taraf == KAYNAK_BELLEK) && s.yaz;
        e.obek   = s.obek;
        y.kaynak = s.taraf;
        y.yaz    = e.yaz;
        y.obek   = ref_mem[s.adres[9:4]];
        if (e.yaz) begin
            ref_mem[s.adres[9:4]] = s.obek;
        end
        obek_sirasi.push_back(e);
        yanit_sirasi.push_back(y);
        son_taraf = s.taraf;
        bekleyen_n++;
        if (s.taraf == KAYNAK_GETIR) begin
            getir_istek_valid = 1'b1;
            getir_istek.adres = s.adres;
            getir_bekle = s.bekle;
            getir_yanit_ready = (s.bekle == 0);
        end else begin
            bellek_istek_valid = 1'b1;
            bellek_istek.adres = s.adres;
            bellek_istek.yaz = s.yaz;
            bellek_istek.obek = s.obek;
            bellek_bekle = s.bekle;
            bellek_yanit_ready = (s.bekle == 0);
        end
    endtask

    task automatic watch_response(input kaynak_e taraf, input logic valid, input logic ready,
                                  input logic [127:0] blok);
        if (valid) begin
            if (yanit_sirasi.size() == 0) begin
                report_error("a response came with no request outstanding");
            end else begin
                check_kaynak((taraf == KAYNAK_GETIR) ? "getir_yanit_valid_o"
                                                     : "bellek_yanit_valid_o",
                             taraf, yanit_sirasi[0].kaynak);
                if (!yanit_sirasi[0].yaz) begin
                    check_blok((taraf == KAYNAK_GETIR) ? "getir_yanit_o" : "bellek_yanit_o",
                               blok, yanit_sirasi[0].obek);
                end
                if (ready) begin
                    void'(yanit_sirasi.pop_front());
                    bekleyen_n--;
                end
            end
        end
    endtask

    // Steps cycle by cycle until the launched rows have all been answered
    task automatic run_group();
        logic g_kabul;
        logic b_kabul;
        logic g_teslim;
        logic b_teslim;
        while (bekleyen_n > 0 || getir_istek_valid || bellek_istek_valid) begin
            @(negedge clk);
            g_kabul  = getir_istek_valid && getir_istek_ready;
            b_kabul  = bellek_istek_valid && bellek_istek_ready;
            g_teslim = getir_yanit_valid && getir_yanit_ready;
            b_teslim = bellek_yanit_valid && bellek_yanit_ready;
            if (getir_tut) check_bit("getir_yanit_valid_o", getir_yanit_valid, 1'b1);
            if (bellek_tut) check_bit("bellek_yanit_valid_o", bellek_yanit_valid, 1'b1);
            getir_tut  = getir_yanit_valid && !getir_yanit_ready;
            bellek_tut = bellek_yanit_valid && !bellek_yanit_ready;
            watch_response(KAYNAK_GETIR, getir_yanit_valid, getir_yanit_ready, getir_yanit);
            watch_response(KAYNAK_BELLEK, bellek_yanit_valid, bellek_yanit_ready, bellek_yanit);
            @(posedge clk);
            #2;
            if (g_kabul) getir_istek_valid = 1'b0;
            if (b_kabul) bellek_istek_valid = 1'b0;
            if (g_teslim) begin
                getir_yanit_ready = 1'b0;
            end else if (getir_tut) begin
                getir_bekle = getir_bekle - 1;
                if (getir_bekle <= 0) begin
                    getir_yanit_ready = 1'b1;
                end
            end
            if (b_teslim) begin
                bellek_yanit_ready = 1'b0;
            end else if (bellek_tut) begin
                bellek_bekle = bellek_bekle - 1;
                if (bellek_bekle <= 0) begin
                    bellek_yanit_ready = 1'b1;
                end
            end
        end
    endtask

    // Beat checker on the iomem bus
    always @(negedge clk) begin
        if (iomem_valid && iomem_ready) begin
            if (vurus_n == 0) begin
                if (obek_sirasi.size() == 0) begin
                    report_error("an iomem beat started with no block expected");
                end else begin
                    simdiki = obek_sirasi.pop_front();
                end
            end
            check_kelime("iomem_addr_o", iomem_addr, simdiki.adres + 32'(4 * vurus_n));
            check_kelime("iomem_wstrb_o", 32'(iomem_wstrb), simdiki.yaz ? 32'hf : 32'h0);
            if (simdiki.yaz) begin
                check_kelime("iomem_wdata_o", iomem_wdata, simdiki.obek[vurus_n*32 +: 32]);
            end
            vurus_n = (vurus_n + 1) % `ANABELLEK_VURUS_SAYISI;
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        dongu_n++;
        if (dongu_n >= SINIR) begin
            $display("Timeout: the run did not finish within %0d cycles", SINIR);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int i;
        int b;
        int k;
        rst_n = 1'b0;
        getir_istek_valid = 1'b0;
        getir_istek = '0;
        bellek_istek_valid = 1'b0;
        bellek_istek = '0;
        getir_yanit_ready = 1'b0;
        bellek_yanit_ready = 1'b0;
        hata_n = 0;
        dongu_n = 0;
        vurus_n = 0;
        bekleyen_n = 0;
        getir_tut = 1'b0;
        bellek_tut = 1'b0;
        simdiki = '0;
        son_taraf = KAYNAK_GETIR;
        for (b = 0; b < 64; b++) begin
            for (k = 0; k < 4; k++) begin
                ref_mem[b][k*32 +: 32] = fill_word(32'(b * 16 + k * 4));
            end
        end
        add_row(0, KAYNAK_BELLEK, 1'b1, 32'h040, 128'ha0a0_0003_a0a0_0002_a0a0_0001_a0a0_0000, 0, 0);
        add_row(1, KAYNAK_BELLEK, 1'b0, 32'h040, '0, 0, 0);
        add_row(2, KAYNAK_GETIR, 1'b0, 32'h040, '0, 0, 0);
        add_row(3, KAYNAK_BELLEK, 1'b1, 32'h100, 128'hb1b1_0013_b1b1_0012_b1b1_0011_b1b1_0010, 0, 1);
        add_row(4, KAYNAK_GETIR, 1'b0, 32'h10c, '0, 0, 2);   // Low address bits ignored
        add_row(5, KAYNAK_GETIR, 1'b0, 32'h040, '0, 1, 3);
        add_row(6, KAYNAK_BELLEK, 1'b1, 32'h200, 128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0, 0, 2);
        add_row(7, KAYNAK_BELLEK, 1'b0, 32'h208, '0, 0, 5);
        add_row(8, KAYNAK_BELLEK, 1'b0, 32'h300, '0, 0, 0);   // Never written
        add_row(9, KAYNAK_BELLEK, 1'b0, 32'h100, '0, 1, 4);
        add_row(10, KAYNAK_GETIR, 1'b0, 32'h200, '0, 0, 4);
        add_row(11, KAYNAK_BELLEK, 1'b0, 32'h040, '0, 0, 1);
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_bit("iomem_valid_o", iomem_valid, 1'b0);
        check_bit("getir_yanit_valid_o", getir_yanit_valid, 1'b0);
        check_bit("bellek_yanit_valid_o", bellek_yanit_valid, 1'b0);
        check_bit("getir_istek_ready_o", getir_istek_ready, 1'b1);
        check_bit("bellek_istek_ready_o", bellek_istek_ready, 1'b1);
        i = 0;
        while (i < SATIR_N) begin
            if (tablo[i].birlikte) begin
                // On a tie the side not served last goes first
                if (tablo[i].taraf == son_taraf) begin
                    launch_row(i + 1);
                    launch_row(i);
                end else begin
                    launch_row(i);
                    launch_row(i + 1);
                end
                i = i + 2;
            end else begin
                launch_row(i);
                i = i + 1;
            end
            run_group();
        end
        repeat (5) @(posedge clk);
        if (obek_sirasi.size() != 0 || vurus_n != 0) begin
            report_error("some blocks never completed their iomem beats");
        end
        $display("Errors: %0d", hata_n);
        if (hata_n == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+rtl
rtl/anabellek_pkg.sv
rtl/istek_kuyrugu.sv
rtl/istek_hakemi.sv
rtl/obek_aktarici.sv
rtl/yanit_dagitici.sv
rtl/anabellek_denetleyici.sv
tests/iomem_model.sv
tests/tb_anabellek_denetleyici.sv

/* Bender.yml */
package:
  name: anabellek_denetleyici

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/anabellek_pkg.sv
      - rtl/istek_kuyrugu.sv
      - rtl/istek_hakemi.sv
      - rtl/obek_aktarici.sv
      - rtl/yanit_dagitici.sv
      - rtl/anabellek_denetleyici.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/iomem_model.sv
      - tests/tb_anabellek_denetleyici.sv
